/* common/iopage_pkg.sv */
/*
 * iopage shared definitions: register addresses, interrupt vectors,
 * console timing and the bus and reply types used by every device block.
 */
package iopage_pkg;

   localparam int IOPAGE_AW = 13;

   localparam logic [IOPAGE_AW-1:0] ADDR_SWITCH  = 13'o17570;
   localparam logic [IOPAGE_AW-1:0] ADDR_PSW     = 13'o17776;
   localparam logic [IOPAGE_AW-1:0] ADDR_CLK_CSR = 13'o17546;
   localparam logic [IOPAGE_AW-1:0] ADDR_TT_XCSR = 13'o17564;
   localparam logic [IOPAGE_AW-1:0] ADDR_TT_XBUF = 13'o17566;

   localparam logic [7:0] VEC_CLK = 8'o100;
   localparam logic [7:0] VEC_TT  = 8'o064;

   localparam int IPL_CLK_BIT = 6;
   localparam int IPL_TT_BIT  = 4;

   localparam int TT_BIT_CYCLES = 16;
   localparam int TT_CNT_W      = $clog2(TT_BIT_CYCLES);
   localparam int TT_FRAME_BITS = 10; // start, 8 data, stop.

   typedef struct packed {
      logic [IOPAGE_AW-1:0] addr;
      logic [15:0]          wdata;
      logic                 rd;
      logic                 wr;
      logic                 byte_op;
   } iopage_req_t;

   typedef struct packed {
      logic [15:0] rdata;
      logic        decode;
   } dev_resp_t;

   typedef struct packed {
      logic       request;
      logic [7:0] vector;
   } irq_t;

   typedef struct packed {
      logic [7:0] unused_hi;
      logic       monitor;
      logic       enable;
      logic [5:0] unused_lo;
   } lclk_csr_t;

   typedef struct packed {
      logic [7:0] unused_hi;
      logic       ready;
      logic       enable;
      logic [5:0] unused_lo;
   } tt_xcsr_t;

   typedef union packed {
      lclk_csr_t lclk;
      tt_xcsr_t  xcsr;
   } csr_word_u;

   // registers sit on word addresses, so an odd byte address hits the same word.
   function automatic logic word_match(input logic [IOPAGE_AW-1:0] addr,
                                       input logic [IOPAGE_AW-1:0] word);
      return addr[IOPAGE_AW-1:1] == word[IOPAGE_AW-1:1];
   endfunction

   // true when the access touches the low byte of the word.
   function automatic logic low_lane(input iopage_req_t req);
      return !(req.byte_op && req.addr[0]);
   endfunction

   function automatic logic [15:0] lane_merge(input logic [15:0] old_word,
                                              input iopage_req_t req);
      logic [15:0] merged;
      merged = req.wdata;
      if (req.byte_op)
      begin
         if (req.addr[0])
            merged = {req.wdata[15:8], old_word[7:0]};
         else
            merged = {old_word[15:8], req.wdata[7:0]};
      end
      return merged;
   endfunction

endpackage

/* design/switch_reg.sv */
/*
 * Front panel switch and display register. Reads return the switches,
 * writes load the display lights with byte lane support.
 */
`timescale 1ns/1ps

module switch_reg (
   input  logic                    clk,
   input  logic                    reset,
   input  iopage_pkg::iopage_req_t req,
   output iopage_pkg::dev_resp_t   resp,
   input  logic [15:0]             switches,
   output logic [15:0]             display
);

   logic        wr_display;
   logic [15:0] display_q;

   assign resp.decode = iopage_pkg::word_match(req.addr, iopage_pkg::ADDR_SWITCH);
   assign resp.rdata  = switches;

   assign wr_display = req.wr & resp.decode;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         display_q <= 16'h0000;
      end
      else if (wr_display)
      begin
         display_q <= iopage_pkg::lane_merge(display_q, req); // untouched lane keeps its bits.
      end
   end

   assign display = display_q;

endmodule

/* design/psw_reg.sv */
/*
 * Processor status word window. Reads show the live PSW and a write
 * strobes the CPU to load the bus data into its status word.
 */
`timescale 1ns/1ps

module psw_reg (
   input  iopage_pkg::iopage_req_t req,
   output iopage_pkg::dev_resp_t   resp,
   input  logic [15:0]             psw,
   output logic                    psw_io_wr
);

   logic psw_hit;

   assign psw_hit = iopage_pkg::word_match(req.addr, iopage_pkg::ADDR_PSW);

   assign resp.decode = psw_hit;
   assign resp.rdata  = psw;

   // the CPU owns the register and takes data_in in this same cycle.
   assign psw_io_wr = req.wr & psw_hit;

endmodule

/* design/line_clock.sv */
/*
 * Line clock. Holds the monitor and interrupt enable bits of the clock CSR
 * and raises an interrupt on each mains tick while enabled.
 */
`timescale 1ns/1ps

module line_clock (
   input  logic                    clk,
   input  logic                    reset,
   input  iopage_pkg::iopage_req_t req,
   output iopage_pkg::dev_resp_t   resp,
   input  logic                    lclk_tick,
   input  logic                    interrupt_ack,
   output iopage_pkg::irq_t        irq
);

   iopage_pkg::csr_word_u wr_word;
   logic                  wr_csr;
   logic                  monitor_q;
   logic                  enable_q;
   logic                  request_q;

   assign resp.decode = iopage_pkg::word_match(req.addr, iopage_pkg::ADDR_CLK_CSR);
   assign resp.rdata  = {8'h00, monitor_q, enable_q, 6'b000000};

   assign wr_word = req.wdata;
   assign wr_csr  = req.wr & resp.decode & iopage_pkg::low_lane(req); // both bits live in the low byte.

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         monitor_q <= 1'b0;
         enable_q  <= 1'b0;
         request_q <= 1'b0;
      end
      else
      begin
         if (wr_csr)
         begin
            enable_q <= wr_word.lclk.enable;
            if (!wr_word.lclk.monitor)
               monitor_q <= 1'b0; // software can only clear monitor.
         end
         if (lclk_tick)
            monitor_q <= 1'b1;

         if (interrupt_ack)
            request_q <= 1'b0;
         if (lclk_tick && enable_q)
            request_q <= 1'b1; // a fresh tick beats a same-cycle ack.
      end
   end

   assign irq.request = request_q;
   assign irq.vector  = iopage_pkg::VEC_CLK;

endmodule

/* console/console_tx.sv */
/*
 * Console transmitter. XCSR and XBUF registers, a 10 bit serial shifter
 * clocked by a fixed bit-period divider, and the transmit interrupt.
 */
`timescale 1ns/1ps

module console_tx (
   input  logic                    clk,
   input  logic                    reset,
   input  iopage_pkg::iopage_req_t req,
   output iopage_pkg::dev_resp_t   resp,
   input  logic                    interrupt_ack,
   output iopage_pkg::irq_t        irq,
   output logic                    tx
);

   iopage_pkg::csr_word_u                  wr_word;
   logic                                   xcsr_hit;
   logic                                   xbuf_hit;
   logic                                   wr_low;
   logic                                   wr_xcsr;
   logic                                   wr_xbuf;
   logic                                   ready_q;
   logic                                   enable_q;
   logic                                   request_q;
   logic [7:0]                             xbuf_q;
   logic [iopage_pkg::TT_FRAME_BITS-1:0]   shift_q;
   logic [iopage_pkg::TT_CNT_W-1:0]        cycle_cnt;
   logic [3:0]                             bit_cnt;
   logic                                   bit_end;
   logic                                   frame_done;

   assign xcsr_hit = iopage_pkg::word_match(req.addr, iopage_pkg::ADDR_TT_XCSR);
   assign xbuf_hit = iopage_pkg::word_match(req.addr, iopage_pkg::ADDR_TT_XBUF);

   assign resp.decode = xcsr_hit | xbuf_hit;
   assign resp.rdata  = xbuf_hit ? {8'h00, xbuf_q} : {8'h00, ready_q, enable_q, 6'b000000};

   assign wr_word = req.wdata;
   assign wr_low  = req.wr & iopage_pkg::low_lane(req);
   assign wr_xcsr = wr_low & xcsr_hit;
   assign wr_xbuf = wr_low & xbuf_hit & ready_q; // busy writes are dropped.

   assign bit_end    = cycle_cnt == iopage_pkg::TT_CNT_W'(iopage_pkg::TT_BIT_CYCLES - 1);
   assign frame_done = !ready_q && bit_end &&
                       bit_cnt == 4'(iopage_pkg::TT_FRAME_BITS - 1);

   // shift_q idles all ones so tx rests high between frames.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         shift_q   <= '1;
         cycle_cnt <= '0;
         bit_cnt   <= 4'd0;
         ready_q   <= 1'b1;
      end
      else if (wr_xbuf)
      begin
         shift_q   <= {1'b1, req.wdata[7:0], 1'b0}; // stop, data, start.
         cycle_cnt <= '0;
         bit_cnt   <= 4'd0;
         ready_q   <= 1'b0;
      end
      else if (!ready_q)
      begin
         cycle_cnt <= cycle_cnt + 1'b1;
         if (bit_end)
         begin
            cycle_cnt <= '0;
            shift_q   <= {1'b1, shift_q[iopage_pkg::TT_FRAME_BITS-1:1]};
            bit_cnt   <= bit_cnt + 4'd1;
         end
         if (frame_done)
            ready_q <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_xbuf)
         xbuf_q <= req.wdata[7:0];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         enable_q  <= 1'b0;
         request_q <= 1'b0;
      end
      else
      begin
         if (wr_xcsr)
            enable_q <= wr_word.xcsr.enable;

         if (interrupt_ack)
            request_q <= 1'b0;
         if (frame_done && enable_q)
            request_q <= 1'b1;
         if (wr_xcsr && wr_word.xcsr.enable && !enable_q && ready_q)
            request_q <= 1'b1; // enabling while idle interrupts at once.
      end
   end

   assign tx          = shift_q[0];
   assign irq.request = request_q;
   assign irq.vector  = iopage_pkg::VEC_TT;

endmodule

/* design/iopage.sv */
/*
 * I/O page top level. Decodes the bus request, multiplexes device read data,
 * flags unclaimed accesses and merges device interrupts into one request.
 */
`timescale 1ns/1ps

module iopage (
   input  logic        clk,
   input  logic        reset,
   input  logic [21:0] address,
   input  logic [15:0] data_in,
   input  logic        iopage_rd,
   input  logic        iopage_wr,
   input  logic        iopage_byte_op,
   output logic [15:0] data_out,
   output logic        no_decode,
   output logic        interrupt,
   output logic [7:0]  interrupt_ipl,
   input  logic [7:0]  ack_ipl,
   output logic [7:0]  vector,
   input  logic [15:0] switches,
   output logic [15:0] display,
   input  logic [15:0] psw,
   output logic        psw_io_wr,
   input  logic        lclk_tick,
   output logic        tx
);

   iopage_pkg::iopage_req_t req;
   iopage_pkg::dev_resp_t   sw_resp;
   iopage_pkg::dev_resp_t   psw_resp;
   iopage_pkg::dev_resp_t   clk_resp;
   iopage_pkg::dev_resp_t   tt_resp;
   iopage_pkg::irq_t        clk_irq;
   iopage_pkg::irq_t        tt_irq;
   logic                    good_decode;

   assign req.addr    = address[iopage_pkg::IOPAGE_AW-1:0]; // upper bits select the page.
   assign req.wdata   = data_in;
   assign req.rd      = iopage_rd;
   assign req.wr      = iopage_wr;
   assign req.byte_op = iopage_byte_op;

   assign data_out = sw_resp.decode  ? sw_resp.rdata :
                     psw_resp.decode ? psw_resp.rdata :
                     clk_resp.decode ? clk_resp.rdata :
                     tt_resp.decode  ? tt_resp.rdata :
                     16'h0000;

   assign good_decode = sw_resp.decode | psw_resp.decode | clk_resp.decode | tt_resp.decode;
   assign no_decode   = (iopage_rd | iopage_wr) & ~good_decode;

   assign interrupt = clk_irq.request | tt_irq.request;

   always_comb
   begin
      interrupt_ipl = 8'h00;
      interrupt_ipl[iopage_pkg::IPL_CLK_BIT] = clk_irq.request;
      interrupt_ipl[iopage_pkg::IPL_TT_BIT]  = tt_irq.request;
   end

   // the line clock wins when both devices are waiting.
   assign vector = clk_irq.request ? clk_irq.vector :
                   tt_irq.request  ? tt_irq.vector :
                   8'h00;

   switch_reg u_switch_reg (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .resp     (sw_resp),
      .switches (switches),
      .display  (display)
   );

   psw_reg u_psw_reg (
      .req       (req),
      .resp      (psw_resp),
      .psw       (psw),
      .psw_io_wr (psw_io_wr)
   );

   line_clock u_line_clock (
      .clk           (clk),
      .reset         (reset),
      .req           (req),
      .resp          (clk_resp),
      .lclk_tick     (lclk_tick),
      .interrupt_ack (ack_ipl[iopage_pkg::IPL_CLK_BIT]),
      .irq           (clk_irq)
   );

   console_tx u_console_tx (
      .clk           (clk),
      .reset         (reset),
      .req           (req),
      .resp          (tt_resp),
      .interrupt_ack (ack_ipl[iopage_pkg::IPL_TT_BIT]),
      .irq           (tt_irq),
      .tx            (tx)
   );

endmodule

/* tests/iopage_assertions.sv */
/*
 * iopage assertions. Decode, PSW strobe, interrupt vector and serial line rules.
 */
`timescale 1ns/1ps

module iopage_assertions (
   input logic       clk,
   input logic       reset,
   input logic [3:0] decodes,
   input logic       no_decode,
   input logic       iopage_wr,
   input logic       psw_io_wr,
   input logic       interrupt,
   input logic [7:0] vector,
   input logic       tx
);

   logic reset_seen = 1'b0;

   always_ff @(posedge clk)
   begin
      if (reset)
         reset_seen <= 1'b1; // the shifter is loaded from the first reset edge on.
   end

   one_decode: assert property (@(posedge clk) disable iff (reset) $onehot0(decodes))
      else $error("more than one device decodes the address");

   claimed_access: assert property (@(posedge clk) disable iff (reset)
      !(no_decode && (decodes != 4'b0000)))
      else $error("no_decode is high while a device decodes");

   psw_strobe: assert property (@(posedge clk) disable iff (reset) psw_io_wr |-> iopage_wr)
      else $error("psw_io_wr without a bus write");

   irq_vector: assert property (@(posedge clk) disable iff (reset) interrupt |-> vector != 8'h00)
      else $error("interrupt with a zero vector");

   tx_idle: assert property (@(posedge clk) (reset && reset_seen) |-> tx)
      else $error("tx is low during reset");

endmodule

bind iopage iopage_assertions u_assertions (
   .clk       (clk),
   .reset     (reset),
   .decodes   ({sw_resp.decode, psw_resp.decode, clk_resp.decode, tt_resp.decode}),
   .no_decode (no_decode),
   .iopage_wr (iopage_wr),
   .psw_io_wr (psw_io_wr),
   .interrupt (interrupt),
   .vector    (vector),
   .tx        (tx)
);

/* tests/iopage_tb.sv */
/*
 * iopage testbench. Directed and random bus traffic checked every cycle
 * against a model of the switch, PSW, line clock and console registers.
 */
`timescale 1ns/1ps

module iopage_tb;

   logic        clk = 1'b0;
   logic        reset;
   logic [21:0] address;
   logic [15:0] data_in;
   logic        iopage_rd;
   logic        iopage_wr;
   logic        iopage_byte_op;
   logic [15:0] data_out;
   logic        no_decode;
   logic        interrupt;
   logic [7:0]  interrupt_ipl;
   logic [7:0]  ack_ipl;
   logic [7:0]  vector;
   logic [15:0] switches;
   logic [15:0] display;
   logic [15:0] psw;
   logic        psw_io_wr;
   logic        lclk_tick;
   logic        tx;

   integer      seed = 47;
   int          errors = 0;
   int          errors_at_start = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int          cycle_no = 0;
   logic [15:0] last_rdata;

   logic [15:0] m_display;
   logic        m_monitor;
   logic        m_clk_en;
   logic        m_clk_req;
   logic        m_ready;
   logic        m_tt_en;
   logic        m_tt_req;
   logic [7:0]  m_xbuf;
   logic        m_xbuf_valid; // xbuf has no reset value.
   logic [9:0]  m_frame;
   int          m_tt_count;

   iopage UUT (.*);

   always #5 clk = ~clk;

   task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_irq(input iopage_pkg::irq_t got, input iopage_pkg::irq_t exp,
                            input logic [7:0] got_ipl, input logic [7:0] exp_ipl,
                            input string what);
      if (got !== exp || got_ipl !== exp_ipl)
      begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s is %h ipl %h, expected %h ipl %h",
                  $time, what, got, got_ipl, exp, exp_ipl);
      end
   endtask

   function automatic iopage_pkg::iopage_req_t make_req(input logic [12:0] addr,
      input logic [15:0] wdata, input logic rd, input logic wr, input logic byte_op);
      return {addr, wdata, rd, wr, byte_op};
   endfunction

   // drives one bus cycle 1 ns after a rising edge and checks the outputs before the next edge.
   task automatic run_cycle(input iopage_pkg::iopage_req_t r, input logic tick,
                            input logic [7:0] ack);
      int               rnd;
      logic [12:0]      word;
      logic             sw_hit;
      logic             psw_hit;
      logic             clk_hit;
      logic             xcsr_hit;
      logic             xbuf_hit;
      logic             low;
      logic             accept;
      logic             finish;
      logic [15:0]      exp_data;
      logic [9:0]       frame_shifted;
      iopage_pkg::irq_t exp_irq;
      rnd = $random(seed);
      address = {rnd[8:0], r.addr}; // bits above the page are ignored.
      data_in = r.wdata;
      iopage_rd = r.rd;
      iopage_wr = r.wr;
      iopage_byte_op = r.byte_op;
      lclk_tick = tick;
      ack_ipl = ack;
      rnd = $random(seed);
      switches = rnd[15:0];
      psw = rnd[31:16];
      #3;
      word = {r.addr[12:1], 1'b0};
      sw_hit = word == iopage_pkg::ADDR_SWITCH;
      psw_hit = word == iopage_pkg::ADDR_PSW;
      clk_hit = word == iopage_pkg::ADDR_CLK_CSR;
      xcsr_hit = word == iopage_pkg::ADDR_TT_XCSR;
      xbuf_hit = word == iopage_pkg::ADDR_TT_XBUF;
      low = !(r.byte_op && r.addr[0]);
      exp_data = 16'h0000;
      if (sw_hit)
         exp_data = switches;
      else if (psw_hit)
         exp_data = psw;
      else if (clk_hit)
         exp_data = {8'h00, m_monitor, m_clk_en, 6'h00};
      else if (xcsr_hit)
         exp_data = {8'h00, m_ready, m_tt_en, 6'h00};
      else if (xbuf_hit)
         exp_data = {8'h00, m_xbuf};
      last_rdata = data_out;
      if (r.rd && !(xbuf_hit && !m_xbuf_valid))
         check_word(data_out, exp_data, "read data");
      check_bit(no_decode, (r.rd | r.wr) & ~(sw_hit | psw_hit | clk_hit | xcsr_hit | xbuf_hit),
                "no_decode");
      check_bit(psw_io_wr, r.wr & psw_hit, "psw_io_wr");
      check_word(display, m_display, "display");
      frame_shifted = m_frame >> (m_tt_count / 16);
      check_bit(tx, m_ready | frame_shifted[0], "tx");
      exp_irq.request = m_clk_req | m_tt_req;
      exp_irq.vector = m_clk_req ? iopage_pkg::VEC_CLK : (m_tt_req ? iopage_pkg::VEC_TT : 8'h00);
      check_irq({interrupt, vector}, exp_irq, interrupt_ipl,
                {1'b0, m_clk_req, 1'b0, m_tt_req, 4'h0}, "interrupt");

      // every next-state rule reads the model values from before this edge.
      if (r.wr && sw_hit)
      begin
         if (!r.byte_op)
            m_display = r.wdata;
         else if (r.addr[0])
            m_display[15:8] = r.wdata[15:8];
         else
            m_display[7:0] = r.wdata[7:0];
      end
      if (ack[6])
         m_clk_req = 1'b0;
      if (tick && m_clk_en)
         m_clk_req = 1'b1;
      if (r.wr && clk_hit && low)
      begin
         m_clk_en = r.wdata[6];
         if (!r.wdata[7])
            m_monitor = 1'b0;
      end
      if (tick)
         m_monitor = 1'b1;
      accept = r.wr && xbuf_hit && low && m_ready;
      finish = !m_ready && m_tt_count == 159;
      if (ack[4])
         m_tt_req = 1'b0;
      if (finish && m_tt_en)
         m_tt_req = 1'b1;
      if (r.wr && xcsr_hit && low && r.wdata[6] && !m_tt_en && m_ready)
         m_tt_req = 1'b1;
      if (r.wr && xcsr_hit && low)
         m_tt_en = r.wdata[6];
      if (accept)
      begin
         m_ready = 1'b0;
         m_tt_count = 0;
         m_frame = {1'b1, r.wdata[7:0], 1'b0};
         m_xbuf = r.wdata[7:0];
         m_xbuf_valid = 1'b1;
      end
      else if (!m_ready)
      begin
         m_tt_count++;
         if (finish)
            m_ready = 1'b1;
      end
      @(posedge clk);
      #1;
      cycle_no++;
   endtask

   task automatic write_word(input logic [12:0] addr, input logic [15:0] data);
      run_cycle(make_req(addr, data, 1'b0, 1'b1, 1'b0), 1'b0, 8'h00);
   endtask

   task automatic write_byte(input logic [12:0] addr, input logic [15:0] data);
      run_cycle(make_req(addr, data, 1'b0, 1'b1, 1'b1), 1'b0, 8'h00);
   endtask

   task automatic read_word(input logic [12:0] addr);
      run_cycle(make_req(addr, 16'h0000, 1'b1, 1'b0, 1'b0), 1'b0, 8'h00);
   endtask

   task automatic pulse(input logic tick, input logic [7:0] ack);
      run_cycle(make_req(13'h0000, 16'h0000, 1'b0, 1'b0, 1'b0), tick, ack);
   endtask

   task automatic end_test(input string name);
      if (errors == errors_at_start)
      begin
         tests_passed++;
         $display("test %s: passed", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   initial
   begin
      int                      rnd;
      int                      n;
      int                      idx;
      int                      start;
      int                      ready_at;
      int                      bits_seen;
      logic [7:0]              tx_byte;
      logic [9:0]              tx_frame;
      logic [7:0]              ack;
      iopage_pkg::iopage_req_t r;
      reset = 1'b1;
      address = '0;
      data_in = 16'h0000;
      iopage_rd = 1'b0;
      iopage_wr = 1'b0;
      iopage_byte_op = 1'b0;
      ack_ipl = 8'h00;
      switches = 16'h0000;
      psw = 16'h0000;
      lclk_tick = 1'b0;
      m_display = 16'h0000;
      m_monitor = 1'b0;
      m_clk_en = 1'b0;
      m_clk_req = 1'b0;
      m_ready = 1'b1;
      m_tt_en = 1'b0;
      m_tt_req = 1'b0;
      m_xbuf = 8'h00;
      m_xbuf_valid = 1'b0;
      m_frame = '1;
      m_tt_count = 0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;

      repeat (8)
      begin
         rnd = $random(seed);
         write_word(iopage_pkg::ADDR_SWITCH, rnd[15:0]);
         write_byte(iopage_pkg::ADDR_SWITCH, rnd[31:16]);
         write_byte(iopage_pkg::ADDR_SWITCH | 13'd1, rnd[23:8]);
         read_word(iopage_pkg::ADDR_SWITCH);
      end
      end_test("display register writes");

      repeat (8)
      begin
         rnd = $random(seed);
         read_word(iopage_pkg::ADDR_PSW);
         write_word(iopage_pkg::ADDR_PSW, rnd[15:0]);
         write_byte(iopage_pkg::ADDR_PSW | 13'd1, rnd[31:16]);
         write_word(13'o17000, rnd[15:0]);
      end
      end_test("psw window");

      write_word(iopage_pkg::ADDR_CLK_CSR, 16'h0040);
      pulse(1'b1, 8'h00);
      read_word(iopage_pkg::ADDR_CLK_CSR);
      check_word(last_rdata, 16'h00c0, "clock csr after tick");
      check_irq({interrupt, vector}, {1'b1, 8'o100}, interrupt_ipl, 8'h40, "clock request");
      pulse(1'b0, 8'h40);
      check_bit(interrupt, 1'b0, "interrupt after clock ack");
      write_word(iopage_pkg::ADDR_CLK_CSR, 16'h0000);
      read_word(iopage_pkg::ADDR_CLK_CSR);
      check_word(last_rdata, 16'h0000, "clock csr after clear");
      end_test("line clock");

      rnd = $random(seed);
      tx_byte = rnd[7:0];
      write_word(iopage_pkg::ADDR_TT_XCSR, 16'h0000);
      write_word(iopage_pkg::ADDR_TT_XBUF, {8'h00, tx_byte});
      start = cycle_no;
      read_word(iopage_pkg::ADDR_TT_XCSR);
      check_word(last_rdata, 16'h0000, "xcsr after xbuf write");
      ready_at = -1;
      bits_seen = 0;
      for (n = 0; n < 400 && ready_at < 0; n++)
      begin
         if ((cycle_no - start) % 16 == 8)
         begin
            idx = (cycle_no - start) / 16;
            tx_frame = {1'b1, tx_byte, 1'b0} >> idx; // start bit first, data LSB first.
            bits_seen++;
            check_bit(tx, tx_frame[0], "tx mid-bit");
         end
         if (cycle_no - start == 40)
            write_word(iopage_pkg::ADDR_TT_XBUF, {8'h00, ~tx_byte});
         else
         begin
            read_word(iopage_pkg::ADDR_TT_XCSR);
            if (last_rdata[7])
               ready_at = cycle_no - 1 - start;
         end
      end
      if (ready_at < 0)
      begin
         errors++;
         $display("timeout: console ready did not return within 400 cycles");
      end
      else
         check_word(16'(ready_at), 16'd160, "cycles until ready");
      check_word(16'(bits_seen), 16'd10, "tx bits sampled");
      read_word(iopage_pkg::ADDR_TT_XBUF);
      check_word(last_rdata, {8'h00, tx_byte}, "xbuf after busy write");
      end_test("console transmit");

      write_word(iopage_pkg::ADDR_TT_XCSR, 16'h0040);
      write_word(iopage_pkg::ADDR_CLK_CSR, 16'h0040);
      pulse(1'b1, 8'h00);
      check_word({8'h00, vector}, 16'o100, "vector with both requests");
      check_word({8'h00, interrupt_ipl}, 16'h0050, "ipl with both requests");
      pulse(1'b0, 8'h40);
      check_word({8'h00, vector}, 16'o064, "vector after clock ack");
      pulse(1'b0, 8'h10);
      check_bit(interrupt, 1'b0, "interrupt after console ack");
      write_word(iopage_pkg::ADDR_TT_XCSR, 16'h0000);
      write_word(iopage_pkg::ADDR_CLK_CSR, 16'h0000);
      end_test("interrupt priority");

      for (n = 0; n < 3000; n++)
      begin
         rnd = $random(seed);
         case (rnd[2:0])
            3'd0: r.addr = iopage_pkg::ADDR_SWITCH;
            3'd1: r.addr = iopage_pkg::ADDR_PSW;
            3'd2: r.addr = iopage_pkg::ADDR_CLK_CSR;
            3'd3: r.addr = iopage_pkg::ADDR_TT_XCSR;
            3'd4: r.addr = iopage_pkg::ADDR_TT_XBUF;
            default: r.addr = rnd[15:3];
         endcase
         if (rnd[2:0] < 3'd5)
            r.addr[0] = rnd[16];
         r.rd = rnd[18:17] == 2'd1;
         r.wr = rnd[18:17] == 2'd2;
         r.byte_op = rnd[19];
         ack = 8'h00;
         ack[6] = m_clk_req && rnd[25];
         ack[4] = m_tt_req && rnd[26];
         rnd = $random(seed) ^ rnd;
         r.wdata = rnd[15:0];
         run_cycle(r, rnd[24:20] == 5'd0, ack); // ticks are sparse.
      end
      end_test("random traffic");

      $display("%0d tests passed, %0d tests failed, %0d check errors",
               tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* filelist.f */
common/iopage_pkg.sv
design/switch_reg.sv
design/psw_reg.sv
design/line_clock.sv
console/console_tx.sv
design/iopage.sv
tests/iopage_assertions.sv
tests/iopage_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = iopage_tb
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
